// ==== mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

//* bank layout, word-interleaved on byte address bits 3:2
`define MEM_NUM_BANK   4
`define MEM_BANK_BITS  2
`define MEM_ROW_BITS   8

//* word and byte lanes
`define MEM_DATA_W     32
`define MEM_BE_W       4
`define MEM_ADDR_W     32

//* requesters per sram port, a = {pe1, pe0, conf}, b = {dma1, dma0}
`define MEM_PORTA_REQ  3
`define MEM_PORTB_REQ  2

`endif

// ==== mem_pkg.sv ====
`include "mem_macros.svh"

package mem_pkg;

  //* one requester's access, byte address and full word
  typedef struct packed {
    logic                   rd;
    logic                   wr;
    logic [`MEM_BE_W-1:0]   be;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] wdata;
  } mem_req_t;

  //* command seen by one port of one bank
  //* wstrb is already gated by the write strobe
  typedef struct packed {
    logic                     rd;
    logic [`MEM_BE_W-1:0]     wstrb;
    logic [`MEM_ROW_BITS-1:0] row;
    logic [`MEM_DATA_W-1:0]   wdata;
  } bank_cmd_t;

  //* read response back to one requester
  typedef struct packed {
    logic                   rvalid;
    logic [`MEM_DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage

// ==== bank_arbiter.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module bank_arbiter #(
  parameter int NUM_REQ = 3
) (
  input  mem_pkg::mem_req_t [NUM_REQ-1:0]                     i_req,
  output logic [`MEM_NUM_BANK-1:0][NUM_REQ-1:0]               o_win,
  output logic [NUM_REQ-1:0]                                  o_gnt
);

  logic [NUM_REQ-1:0]                      active;
  logic [NUM_REQ-1:0][`MEM_BANK_BITS-1:0]  bank_sel;

  //* decode activity and target bank per requester
  for (genvar r = 0; r < NUM_REQ; r++) begin : g_dec
    assign active[r]   = i_req[r].rd | i_req[r].wr;
    assign bank_sel[r] = i_req[r].addr[`MEM_BANK_BITS+1:2];
  end

  //* lowest index wins, independently for each bank
  always_comb begin : p_pick
    logic taken;
    o_win = '0;
    for (int b = 0; b < `MEM_NUM_BANK; b++) begin
      taken = 1'b0;
      for (int r = 0; r < NUM_REQ; r++) begin
        if (active[r] && !taken && (bank_sel[r] == `MEM_BANK_BITS'(b))) begin
          o_win[b][r] = 1'b1;
          taken       = 1'b1;
        end
      end
    end
  end

  //* idle requesters see gnt high
  // an active one can only have won the bank its address selects
  for (genvar r = 0; r < NUM_REQ; r++) begin : g_gnt
    assign o_gnt[r] = ~active[r] | o_win[bank_sel[r]][r];
  end

  always_comb begin : p_chk
    for (int b = 0; b < `MEM_NUM_BANK; b++) begin
      a_one_winner: assert ($onehot0(o_win[b]))
        else $error("bank_arbiter: bank %0d has winners %b", b, o_win[b]);
    end
  end

endmodule

// ==== port_crossbar.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module port_crossbar #(
  parameter int NUM_REQ = 3
) (
  input  mem_pkg::mem_req_t  [NUM_REQ-1:0]              i_req,
  input  logic [`MEM_NUM_BANK-1:0][NUM_REQ-1:0]          i_win,
  output mem_pkg::bank_cmd_t [`MEM_NUM_BANK-1:0]        o_cmd
);

  localparam int ROW_LSB = `MEM_BANK_BITS + 2;
  localparam int ROW_MSB = ROW_LSB + `MEM_ROW_BITS - 1;

  //* per requester view of its bank command
  // bits above the row are dropped here, so addresses alias every 4 KB
  mem_pkg::bank_cmd_t [NUM_REQ-1:0] req_cmd;

  for (genvar r = 0; r < NUM_REQ; r++) begin : g_req
    assign req_cmd[r].rd    = i_req[r].rd;
    assign req_cmd[r].wstrb = i_req[r].be & {`MEM_BE_W{i_req[r].wr}};
    assign req_cmd[r].row   = i_req[r].addr[ROW_MSB:ROW_LSB];
    assign req_cmd[r].wdata = i_req[r].wdata;
  end

  //* win matrix is one-hot or empty per bank
  // so an or over the masked commands acts as the mux
  always_comb begin : p_route
    for (int b = 0; b < `MEM_NUM_BANK; b++) begin
      o_cmd[b] = '0;
      for (int r = 0; r < NUM_REQ; r++) begin
        if (i_win[b][r]) begin
          o_cmd[b] = o_cmd[b] | req_cmd[r];
        end
      end
    end
  end

endmodule

// ==== sram_bank.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module sram_bank (
  input  logic                      i_clk,
  input  mem_pkg::bank_cmd_t        i_cmd_a,
  input  mem_pkg::bank_cmd_t        i_cmd_b,
  output logic [`MEM_DATA_W-1:0]    o_rdata_a,
  output logic [`MEM_DATA_W-1:0]    o_rdata_b
);

  localparam int DEPTH  = 2 ** `MEM_ROW_BITS;
  localparam int BYTE_W = `MEM_DATA_W / `MEM_BE_W;

  logic [`MEM_DATA_W-1:0] mem [DEPTH];

  //* read-first, output registers hold until the next read
  always_ff @(posedge i_clk) begin
    if (i_cmd_a.rd) begin
      o_rdata_a <= mem[i_cmd_a.row];
    end
    if (i_cmd_b.rd) begin
      o_rdata_b <= mem[i_cmd_b.row];
    end
  end

  //* port b first, port a last
  // on a same-word collision the later update of a byte is the one kept
  always_ff @(posedge i_clk) begin
    for (int i = 0; i < `MEM_BE_W; i++) begin
      if (i_cmd_b.wstrb[i]) begin
        mem[i_cmd_b.row][i*BYTE_W +: BYTE_W] <= i_cmd_b.wdata[i*BYTE_W +: BYTE_W];
      end
    end
    for (int i = 0; i < `MEM_BE_W; i++) begin
      if (i_cmd_a.wstrb[i]) begin
        mem[i_cmd_a.row][i*BYTE_W +: BYTE_W] <= i_cmd_a.wdata[i*BYTE_W +: BYTE_W];
      end
    end
  end

endmodule

// ==== read_return.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module read_return #(
  parameter int NUM_REQ = 3
) (
  input  logic                                      i_clk,
  input  logic                                      i_rst_n,
  input  logic [`MEM_NUM_BANK-1:0][NUM_REQ-1:0]     i_win,
  input  logic [NUM_REQ-1:0]                        i_rd,
  input  logic [`MEM_NUM_BANK-1:0][`MEM_DATA_W-1:0] i_rdata,
  output mem_pkg::mem_rsp_t [NUM_REQ-1:0]           o_rsp
);

  //* bank owned by each requester, aligned with the sram output register
  logic [NUM_REQ-1:0][`MEM_NUM_BANK-1:0]  own_q;
  logic [NUM_REQ-1:0]                     sel_vld;
  logic [NUM_REQ-1:0][`MEM_DATA_W-1:0]    sel_data;
  logic [NUM_REQ-1:0]                     rvalid_q;
  logic [NUM_REQ-1:0][`MEM_DATA_W-1:0]    rdata_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      own_q <= '0;
    end else begin
      for (int r = 0; r < NUM_REQ; r++) begin
        for (int b = 0; b < `MEM_NUM_BANK; b++) begin
          own_q[r][b] <= i_win[b][r] & i_rd[r];
        end
      end
    end
  end

  //* pick the owned bank's word
  always_comb begin
    for (int r = 0; r < NUM_REQ; r++) begin
      sel_vld[r]  = |own_q[r];
      sel_data[r] = '0;
      for (int b = 0; b < `MEM_NUM_BANK; b++) begin
        if (own_q[r][b]) begin
          sel_data[r] = sel_data[r] | i_rdata[b];
        end
      end
    end
  end

  //* second stage, rvalid is a one cycle pulse per read
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rvalid_q <= '0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= sel_vld;
      for (int r = 0; r < NUM_REQ; r++) begin
        if (sel_vld[r]) begin
          rdata_q[r] <= sel_data[r];
        end
      end
    end
  end

  for (genvar r = 0; r < NUM_REQ; r++) begin : g_rsp
    assign o_rsp[r] = '{rvalid: rvalid_q[r], rdata: rdata_q[r]};

    //* a requester has one address, so the arbiter may hand it one bank at most
    a_single_owner: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $onehot0(own_q[r]))
      else $error("read_return: requester %0d owns banks %b", r, own_q[r]);
  end

endmodule

// ==== memory_top.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module memory_top (
  input  logic                                          i_clk,
  input  logic                                          i_rst_n,

  //* configuration, full-word access on port a
  input  logic                                          i_conf_rden,
  input  logic                                          i_conf_wren,
  input  logic [`MEM_ADDR_W-1:0]                        i_conf_addr,
  input  logic [`MEM_DATA_W-1:0]                        i_conf_wdata,
  output logic [`MEM_DATA_W-1:0]                        o_conf_rdata,
  output logic                                          o_conf_rvalid,
  output logic                                          o_conf_gnt,

  //* pe data lanes, behind conf on port a
  input  logic [`MEM_PORTA_REQ-2:0]                     i_data_req,
  input  logic [`MEM_PORTA_REQ-2:0]                     i_data_we,
  input  logic [`MEM_PORTA_REQ-2:0][`MEM_BE_W-1:0]      i_data_be,
  input  logic [`MEM_PORTA_REQ-2:0][`MEM_ADDR_W-1:0]    i_data_addr,
  input  logic [`MEM_PORTA_REQ-2:0][`MEM_DATA_W-1:0]    i_data_wdata,
  output logic [`MEM_PORTA_REQ-2:0][`MEM_DATA_W-1:0]    o_data_rdata,
  output logic [`MEM_PORTA_REQ-2:0]                     o_data_rvalid,
  output logic [`MEM_PORTA_REQ-2:0]                     o_data_gnt,

  //* dma lanes on port b
  input  logic [`MEM_PORTB_REQ-1:0]                     i_dma_rden,
  input  logic [`MEM_PORTB_REQ-1:0]                     i_dma_wren,
  input  logic [`MEM_PORTB_REQ-1:0][`MEM_ADDR_W-1:0]    i_dma_addr,
  input  logic [`MEM_PORTB_REQ-1:0][`MEM_DATA_W-1:0]    i_dma_wdata,
  output logic [`MEM_PORTB_REQ-1:0][`MEM_DATA_W-1:0]    o_dma_rdata,
  output logic [`MEM_PORTB_REQ-1:0]                     o_dma_rvalid,
  output logic [`MEM_PORTB_REQ-1:0]                     o_dma_gnt
);

  mem_pkg::mem_req_t  [`MEM_PORTA_REQ-1:0]              req_a;
  mem_pkg::mem_req_t  [`MEM_PORTB_REQ-1:0]              req_b;
  logic [`MEM_PORTA_REQ-1:0]                            rd_a, gnt_a;
  logic [`MEM_PORTB_REQ-1:0]                            rd_b, gnt_b;
  logic [`MEM_NUM_BANK-1:0][`MEM_PORTA_REQ-1:0]         win_a;
  logic [`MEM_NUM_BANK-1:0][`MEM_PORTB_REQ-1:0]         win_b;
  mem_pkg::bank_cmd_t [`MEM_NUM_BANK-1:0]               cmd_a, cmd_b;
  logic [`MEM_NUM_BANK-1:0][`MEM_DATA_W-1:0]            rdata_a, rdata_b;
  mem_pkg::mem_rsp_t  [`MEM_PORTA_REQ-1:0]              rsp_a;
  mem_pkg::mem_rsp_t  [`MEM_PORTB_REQ-1:0]              rsp_b;

  //* port a order {pe1, pe0, conf}, index 0 has top priority
  assign req_a[0] = '{rd: i_conf_rden, wr: i_conf_wren, be: {`MEM_BE_W{1'b1}},
                      addr: i_conf_addr, wdata: i_conf_wdata};

  for (genvar p = 0; p < `MEM_PORTA_REQ-1; p++) begin : g_pe
    assign req_a[p+1] = '{rd: i_data_req[p] & ~i_data_we[p], wr: i_data_req[p] & i_data_we[p],
                          be: i_data_be[p], addr: i_data_addr[p], wdata: i_data_wdata[p]};
    assign o_data_rdata[p]  = rsp_a[p+1].rdata;
    assign o_data_rvalid[p] = rsp_a[p+1].rvalid;
    assign o_data_gnt[p]    = gnt_a[p+1];
  end

  for (genvar d = 0; d < `MEM_PORTB_REQ; d++) begin : g_dma
    assign req_b[d] = '{rd: i_dma_rden[d], wr: i_dma_wren[d], be: {`MEM_BE_W{1'b1}},
                        addr: i_dma_addr[d], wdata: i_dma_wdata[d]};
    assign rd_b[d]         = req_b[d].rd;
    assign o_dma_rdata[d]  = rsp_b[d].rdata;
    assign o_dma_rvalid[d] = rsp_b[d].rvalid;
    assign o_dma_gnt[d]    = gnt_b[d];
  end

  for (genvar r = 0; r < `MEM_PORTA_REQ; r++) begin : g_rd_a
    assign rd_a[r] = req_a[r].rd;
  end

  assign o_conf_rdata  = rsp_a[0].rdata;
  assign o_conf_rvalid = rsp_a[0].rvalid;
  assign o_conf_gnt    = gnt_a[0];

  //* port a path
  bank_arbiter #(.NUM_REQ(`MEM_PORTA_REQ)) arb_a_i (
    .i_req   (req_a),
    .o_win   (win_a),
    .o_gnt   (gnt_a)
  );

  port_crossbar #(.NUM_REQ(`MEM_PORTA_REQ)) xbar_a_i (
    .i_req   (req_a),
    .i_win   (win_a),
    .o_cmd   (cmd_a)
  );

  read_return #(.NUM_REQ(`MEM_PORTA_REQ)) ret_a_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_win   (win_a),
    .i_rd    (rd_a),
    .i_rdata (rdata_a),
    .o_rsp   (rsp_a)
  );

  //* port b path
  bank_arbiter #(.NUM_REQ(`MEM_PORTB_REQ)) arb_b_i (
    .i_req   (req_b),
    .o_win   (win_b),
    .o_gnt   (gnt_b)
  );

  port_crossbar #(.NUM_REQ(`MEM_PORTB_REQ)) xbar_b_i (
    .i_req   (req_b),
    .i_win   (win_b),
    .o_cmd   (cmd_b)
  );

  read_return #(.NUM_REQ(`MEM_PORTB_REQ)) ret_b_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_win   (win_b),
    .i_rd    (rd_b),
    .i_rdata (rdata_b),
    .o_rsp   (rsp_b)
  );

  for (genvar b = 0; b < `MEM_NUM_BANK; b++) begin : g_bank
    sram_bank bank_i (
      .i_clk     (i_clk),
      .i_cmd_a   (cmd_a[b]),
      .i_cmd_b   (cmd_b[b]),
      .o_rdata_a (rdata_a[b]),
      .o_rdata_b (rdata_b[b])
    );
  end

endmodule

// ==== tb_memory_top.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module tb_memory_top;

  localparam int NREQ     = 5;
  localparam int WORDS    = 1024;
  localparam int CONF_RD  = 64;
  localparam int RAND_CYC = 3000;
  localparam int DIR_CYC  = 400;
  localparam int WDOG_CYC = WORDS + CONF_RD + RAND_CYC + DIR_CYC + 200;

  logic clk = 1'b0;
  logic rst_n;
  logic conf_rden, conf_wren, conf_rvalid, conf_gnt;
  logic [31:0] conf_addr, conf_wdata, conf_rdata;
  logic [1:0] data_req, data_we, data_rvalid, data_gnt;
  logic [1:0][3:0] data_be;
  logic [1:0][31:0] data_addr, data_wdata, data_rdata;
  logic [1:0] dma_rden, dma_wren, dma_rvalid, dma_gnt;
  logic [1:0][31:0] dma_addr, dma_wdata, dma_rdata;

  //* requester order 0 conf, 1 pe0, 2 pe1, 3 dma0, 4 dma1
  string req_name [NREQ] = '{"conf", "pe0", "pe1", "dma0", "dma1"};
  logic [31:0] model_mem [WORDS];
  mem_pkg::mem_req_t pend [NREQ];
  mem_pkg::mem_rsp_t pipe1 [NREQ];
  mem_pkg::mem_rsp_t pipe2 [NREQ];
  int errors = 0;
  int mark = 0;
  int tests_run = 0;
  int tests_failed = 0;

  always #5 clk = ~clk;

  memory_top dut_i (
    .i_clk (clk), .i_rst_n (rst_n),
    .i_conf_rden (conf_rden), .i_conf_wren (conf_wren), .i_conf_addr (conf_addr),
    .i_conf_wdata (conf_wdata), .o_conf_rdata (conf_rdata), .o_conf_rvalid (conf_rvalid),
    .o_conf_gnt (conf_gnt),
    .i_data_req (data_req), .i_data_we (data_we), .i_data_be (data_be),
    .i_data_addr (data_addr), .i_data_wdata (data_wdata), .o_data_rdata (data_rdata),
    .o_data_rvalid (data_rvalid), .o_data_gnt (data_gnt),
    .i_dma_rden (dma_rden), .i_dma_wren (dma_wren), .i_dma_addr (dma_addr),
    .i_dma_wdata (dma_wdata), .o_dma_rdata (dma_rdata), .o_dma_rvalid (dma_rvalid),
    .o_dma_gnt (dma_gnt)
  );

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic mem_pkg::mem_req_t rand_req(input int i);
    mem_pkg::mem_req_t q;
    int kind;
    kind    = $urandom_range(3);
    q.rd    = (kind == 1);
    q.wr    = (kind >= 2);
    q.be    = (i == 1 || i == 2) ? 4'($urandom) : 4'hf;
    q.addr  = $urandom;
    q.wdata = $urandom;
    return q;
  endfunction

  //* lowest active index on the same port and bank keeps the others waiting
  function automatic logic [NREQ-1:0] grant_model();
    logic [NREQ-1:0] g;
    int lo;
    g = '1;
    for (int i = 0; i < NREQ; i++) begin
      lo = (i < 3) ? 0 : 3;
      for (int j = lo; j < i; j++) begin
        if ((pend[i].rd | pend[i].wr) && (pend[j].rd | pend[j].wr) &&
            pend[i].addr[3:2] == pend[j].addr[3:2]) begin
          g[i] = 1'b0;
        end
      end
    end
    return g;
  endfunction

  task automatic drive_inputs();
    conf_rden  = pend[0].rd;
    conf_wren  = pend[0].wr;
    conf_addr  = pend[0].addr;
    conf_wdata = pend[0].wdata;
    for (int p = 0; p < 2; p++) begin
      data_req[p]   = pend[p+1].rd | pend[p+1].wr;
      data_we[p]    = pend[p+1].wr;
      data_be[p]    = pend[p+1].be;
      data_addr[p]  = pend[p+1].addr;
      data_wdata[p] = pend[p+1].wdata;
      dma_rden[p]   = pend[p+3].rd;
      dma_wren[p]   = pend[p+3].wr;
      dma_addr[p]   = pend[p+3].addr;
      dma_wdata[p]  = pend[p+3].wdata;
    end
  endtask

  task automatic check_outputs();
    logic [NREQ-1:0] got_vld;
    logic [NREQ-1:0][31:0] got_data;
    got_vld  = {dma_rvalid, data_rvalid, conf_rvalid};
    got_data = {dma_rdata, data_rdata, conf_rdata};
    for (int i = 0; i < NREQ; i++) begin
      check_value({"rvalid(", req_name[i], ")"}, 32'(got_vld[i]), 32'(pipe2[i].rvalid));
      if (pipe2[i].rvalid) begin
        check_value({"rdata(", req_name[i], ")"}, got_data[i], pipe2[i].rdata);
      end
    end
  endtask

  //* reads see the word before this edge's writes, port a bytes land last
  task automatic update_model(input logic [NREQ-1:0] g);
    int i;
    logic [9:0] w;
    for (int r = 0; r < NREQ; r++) begin
      pipe2[r] = pipe1[r];
      pipe1[r] = '0;
      if (pend[r].rd && g[r]) begin
        pipe1[r] = '{rvalid: 1'b1, rdata: model_mem[pend[r].addr[11:2]]};
      end
    end
    for (int k = 0; k < NREQ; k++) begin
      i = (k + 3) % NREQ;
      w = pend[i].addr[11:2];
      for (int b = 0; b < 4; b++) begin
        if (pend[i].wr && g[i] && pend[i].be[b]) begin
          model_mem[w][8*b +: 8] = pend[i].wdata[8*b +: 8];
        end
      end
    end
  endtask

  task automatic run_cycle(input bit refill);
    logic [NREQ-1:0] g;
    @(negedge clk);
    check_outputs();
    drive_inputs();
    #1;
    g = grant_model();
    check_value("gnt", 32'({dma_gnt, data_gnt, conf_gnt}), 32'(g));
    @(posedge clk);
    update_model(g);
    for (int i = 0; i < NREQ; i++) begin
      if (g[i]) begin
        pend[i] = refill ? rand_req(i) : '0;
      end
    end
  endtask

  //* held requests must all drain within a few cycles, then responses flush
  task automatic serve_all();
    int n;
    n = 0;
    while (n < 20 && (pend[0].rd | pend[0].wr | pend[1].rd | pend[1].wr | pend[2].rd |
                      pend[2].wr | pend[3].rd | pend[3].wr | pend[4].rd | pend[4].wr)) begin
      run_cycle(1'b0);
      n++;
    end
    if (n == 20) begin
      errors++;
      $display("requests were still waiting after 20 cycles at %0t", $time);
    end
    repeat (3) run_cycle(1'b0);
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - mark);
    end
    mark = errors;
  endtask

  initial begin : watchdog
    #(WDOG_CYC * 10);
    $display("run stopped after %0d cycles without completing", WDOG_CYC);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : main
    int unsigned seed_val;
    logic [31:0] a;
    logic [1:0] bank;
    seed_val = $urandom(14522);
    rst_n = 1'b0;
    for (int i = 0; i < NREQ; i++) begin
      pend[i]  = '0;
      pipe1[i] = '0;
      pipe2[i] = '0;
    end
    drive_inputs();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    repeat (4) run_cycle(1'b0);
    report_test("reset and idle");

    //* fill every word, upper address bits random to exercise aliasing
    for (int idx = 0; idx < WORDS; idx++) begin
      pend[0] = '{rd: 1'b0, wr: 1'b1, be: 4'hf, addr: {20'($urandom), 10'(idx), 2'b00},
                  wdata: (32'(idx) * 32'h0001_0001) ^ 32'h5a5a_c3c3};
      run_cycle(1'b0);
    end
    for (int k = 0; k < CONF_RD; k++) begin
      pend[0] = '{rd: 1'b1, wr: 1'b0, be: 4'hf, addr: $urandom, wdata: '0};
      run_cycle(1'b0);
    end
    serve_all();
    report_test("conf write and read");

    for (int k = 0; k < 8; k++) begin
      a = $urandom;
      pend[1 + k % 2] = '{rd: 1'b0, wr: 1'b1, be: 4'($urandom), addr: a, wdata: $urandom};
      serve_all();
      pend[2 - k % 2] = '{rd: 1'b1, wr: 1'b0, be: 4'hf, addr: a, wdata: '0};
      serve_all();
    end
    report_test("pe byte enables");

    for (int k = 0; k < 8; k++) begin
      bank = 2'($urandom);
      for (int i = 0; i < NREQ; i++) begin
        pend[i] = rand_req(i);
        pend[i].rd = (k % 2 == 0);
        pend[i].wr = (k % 2 == 1);
        pend[i].addr[3:2] = bank;
      end
      serve_all();
    end
    report_test("same bank contention");

    //* pe0 writes partial words, conf always writes the full word
    for (int k = 0; k < 8; k++) begin
      a = $urandom;
      pend[1 - k % 2] = '{rd: 1'b0, wr: 1'b1, be: (k % 2 == 0) ? 4'($urandom) : 4'hf,
                          addr: a, wdata: $urandom};
      pend[3] = '{rd: 1'b0, wr: 1'b1, be: 4'hf, addr: a ^ 32'h0000_f000, wdata: $urandom};
      serve_all();
      pend[4] = '{rd: 1'b1, wr: 1'b0, be: 4'hf, addr: a, wdata: '0};
      serve_all();
    end
    report_test("same word from both ports");

    for (int i = 0; i < NREQ; i++) begin
      pend[i] = rand_req(i);
    end
    repeat (RAND_CYC) run_cycle(1'b1);
    serve_all();
    report_test("random mixed traffic");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+.
mem_pkg.sv
bank_arbiter.sv
port_crossbar.sv
sram_bank.sv
read_return.sv
memory_top.sv
tb_memory_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the banked memory testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_memory_top -o sim_memory_top
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/sim_memory_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0
